/* source/icache.sv */
// Instruction cache top: controller, two ways, LRU and read path.
`default_nettype none

`include "icache_params.svh"

module icache
  import icache_pkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic [`ICACHE_ADDR_BITS-1:0]  PCF,
  input  logic [`ICACHE_WORD_WIDTH-1:0] HRData,
  input  logic                          BusReady,
  output logic [`ICACHE_WORD_WIDTH-1:0] InstrF,
  output logic                          IStall,
  output logic                          HRequestF,
  output logic [`ICACHE_ADDR_BITS-1:0]  HAddrF
);

  logic [`ICACHE_TAG_BITS-1:0]  tag;
  logic [`ICACHE_SET_BITS-1:0]  index;
  logic [`ICACHE_WORD_BITS-1:0] wordOffset;
  logic [`ICACHE_WORD_BITS-1:0] counter;
  logic [`ICACHE_TAG_BITS-1:0]  w1Tag;
  logic [`ICACHE_TAG_BITS-1:0]  w2Tag;
  logic w1Valid;
  logic w2Valid;
  logic w1We;
  logic w2We;
  logic currLru;
  logic rdSel;
  logic hitW1;
  logic hitW2;
  logic fillDone;
  cacheLineT line1;
  cacheLineT line2;

  // fetch address split.
  assign tag        = PCF[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
  assign index      = PCF[`ICACHE_BYTE_BITS + `ICACHE_WORD_BITS +: `ICACHE_SET_BITS];
  assign wordOffset = PCF[`ICACHE_BYTE_BITS +: `ICACHE_WORD_BITS];

  // last beat written closes the refill.
  assign fillDone = (w1We | w2We) & (counter == '1);

  icacheController #(.tagBits(`ICACHE_TAG_BITS)) controller (
    .clk(clk), .reset(reset),
    .W1V(w1Valid), .W2V(w2Valid), .CurrLRU(currLru), .BusReady(BusReady),
    .WordOffset(wordOffset), .W1Tag(w1Tag), .W2Tag(w2Tag), .Tag(tag),
    .Counter(counter), .W1WE(w1We), .W2WE(w2We), .IStall(IStall), .RDSel(rdSel),
    .ResetCounter(), .HRequestF(HRequestF), .HitW1(hitW1), .HitW2(hitW2)
  );

  icacheWay way1 (
    .clk(clk), .reset(reset), .WE(w1We), .Index(index), .Word(counter),
    .WriteTag(tag), .WriteData(HRData), .Valid(w1Valid), .Tag(w1Tag), .Line(line1)
  );

  icacheWay way2 (
    .clk(clk), .reset(reset), .WE(w2We), .Index(index), .Word(counter),
    .WriteTag(tag), .WriteData(HRData), .Valid(w2Valid), .Tag(w2Tag), .Line(line2)
  );

  // only a hit that actually serves a fetch touches the LRU.
  icacheLru lru (
    .clk(clk), .reset(reset), .Index(index),
    .HitW1(hitW1 & ~IStall), .HitW2(hitW2 & ~IStall),
    .FillDone(fillDone), .FillW1(w1We), .CurrLRU(currLru)
  );

  icacheReadPath readPath (
    .clk(clk), .reset(reset), .PCF(PCF), .Line1(line1), .Line2(line2),
    .HitW1(hitW1), .HitW2(hitW2), .RDSel(rdSel), .Counter(counter),
    .HRData(HRData), .BusReady(BusReady), .InstrF(InstrF), .HAddrF(HAddrF)
  );

endmodule

`default_nettype wire

/* source/icacheController.sv */
// Instruction cache control: tag compare, refill FSM, beat counter and way write enables.
`default_nettype none

`include "icache_params.svh"

module icacheController #(
  parameter int tagBits = `ICACHE_TAG_BITS
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         W1V,
  input  logic                         W2V,
  input  logic                         CurrLRU,
  input  logic                         BusReady,
  input  logic [`ICACHE_WORD_BITS-1:0] WordOffset,
  input  logic [tagBits-1:0]           W1Tag,
  input  logic [tagBits-1:0]           W2Tag,
  input  logic [tagBits-1:0]           Tag,
  output logic [`ICACHE_WORD_BITS-1:0] Counter,
  output logic                         W1WE,
  output logic                         W2WE,
  output logic                         IStall,
  output logic                         RDSel,
  output logic                         ResetCounter,
  output logic                         HRequestF,
  output logic                         HitW1,
  output logic                         HitW2
);

  typedef enum logic [1:0] {
    READY,
    MEMREAD,
    NEXTINSTR
  } stateT;

  stateT state;
  stateT nextState;

  logic hit;
  logic beatAccept;
  logic lastBeat;
  logic writeW1;
  logic w1En;
  logic w2En;

  // per-way hit, a valid line with a matching tag.
  assign HitW1 = W1V & (Tag == W1Tag);
  assign HitW2 = W2V & (Tag == W2Tag);
  assign hit   = HitW1 | HitW2;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= READY;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    case (state)
      READY:     nextState = hit ? READY : MEMREAD;
      MEMREAD:   nextState = lastBeat ? NEXTINSTR : MEMREAD;
      NEXTINSTR: nextState = READY;
      default:   nextState = READY;
    endcase
  end

  // a miss requests the bus in the same cycle it is seen.
  assign HRequestF    = ~reset & ((state == MEMREAD) | ((state == READY) & ~hit));  // quiet in reset.
  assign IStall       = HRequestF;
  assign ResetCounter = ((state == READY) & hit) | (state == NEXTINSTR);
  assign RDSel        = (state == NEXTINSTR) & (WordOffset == '1);  // word 3 from bypass.

  assign beatAccept = HRequestF & BusReady;
  assign lastBeat   = beatAccept & (Counter == '1);

  // beat counter, also the word being written.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      Counter <= '0;
    end else if (ResetCounter) begin
      Counter <= '0;
    end else if (beatAccept) begin
      Counter <= Counter + 1'b1;
    end
  end

  // refill way. once word 0 lands, the hit keeps the same way.
  always_comb begin
    writeW1 = ((~W1V & W2V) | CurrLRU) & ~HitW2;
    w1En    = writeW1 | HitW1;
    w2En    = ~w1En;
  end

  assign W1WE = w1En & beatAccept;
  assign W2WE = w2En & beatAccept;

  // a single beat never lands in both ways.
  oneWayWrite: assert property (@(posedge clk) disable iff (reset)
    !(W1WE && W2WE));

  // counter holds unless a beat came in or the FSM cleared it.
  counterHold: assert property (@(posedge clk) disable iff (reset)
    !(BusReady || ResetCounter) |=> $stable(Counter));

endmodule

`default_nettype wire

/* source/icacheLru.sv */
// Per-set LRU bits for the two ways, updated on hits and on refill completion.
`default_nettype none

`include "icache_params.svh"

module icacheLru (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`ICACHE_SET_BITS-1:0] Index,
  input  logic                        HitW1,
  input  logic                        HitW2,
  input  logic                        FillDone,
  input  logic                        FillW1,
  output logic                        CurrLRU
);

  // high means way 1 is the one to replace.
  logic [`ICACHE_SETS-1:0] lruBits;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lruBits <= '1;  // first fill in each set goes to way 1.
    end else if (FillDone) begin
      lruBits[Index] <= ~FillW1;  // the new line is most recent.
    end else if (HitW1) begin
      lruBits[Index] <= 1'b0;
    end else if (HitW2) begin
      lruBits[Index] <= 1'b1;
    end
  end

  assign CurrLRU = lruBits[Index];

endmodule

`default_nettype wire

/* source/icacheReadPath.sv */
// Read path: way and word select, last-beat bypass register and refill address.
`default_nettype none

`include "icache_params.svh"

module icacheReadPath
  import icache_pkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic [`ICACHE_ADDR_BITS-1:0]  PCF,
  input  cacheLineT                     Line1,
  input  cacheLineT                     Line2,
  input  logic                          HitW1,
  input  logic                          HitW2,
  input  logic                          RDSel,
  input  logic [`ICACHE_WORD_BITS-1:0]  Counter,
  input  logic [`ICACHE_WORD_WIDTH-1:0] HRData,
  input  logic                          BusReady,
  output logic [`ICACHE_WORD_WIDTH-1:0] InstrF,
  output logic [`ICACHE_ADDR_BITS-1:0]  HAddrF
);

  cacheLineT                     selLine;
  logic [`ICACHE_WORD_BITS-1:0]  wordOffset;
  logic [`ICACHE_WORD_WIDTH-1:0] arrayWord;
  logic [`ICACHE_WORD_WIDTH-1:0] lastBeat;

  assign wordOffset = PCF[`ICACHE_BYTE_BITS +: `ICACHE_WORD_BITS];

  // line of the hitting way, zero on a miss.
  always_comb begin
    if (HitW1) begin
      selLine.raw = Line1.raw;
    end else if (HitW2) begin
      selLine.raw = Line2.raw;
    end else begin
      selLine.raw = '0;  // stalled anyway.
    end
  end

  assign arrayWord = selLine.words[wordOffset];

  // keeps the most recent beat for the word 3 bypass.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lastBeat <= '0;
    end else if (BusReady) begin
      lastBeat <= HRData;
    end
  end

  assign InstrF = RDSel ? lastBeat : arrayWord;

  // line base plus four bytes per beat.
  assign HAddrF = {PCF[`ICACHE_ADDR_BITS-1:`ICACHE_BYTE_BITS + `ICACHE_WORD_BITS],
                   Counter, {`ICACHE_BYTE_BITS{1'b0}}};

endmodule

`default_nettype wire

/* source/icacheWay.sv */
// One cache way: valid bits, tag array and word-writable line array with combinational read.
`default_nettype none

`include "icache_params.svh"

module icacheWay
  import icache_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         WE,
  input  logic [`ICACHE_SET_BITS-1:0]  Index,
  input  logic [`ICACHE_WORD_BITS-1:0] Word,
  input  logic [`ICACHE_TAG_BITS-1:0]  WriteTag,
  input  logic [`ICACHE_WORD_WIDTH-1:0] WriteData,
  output logic                         Valid,
  output logic [`ICACHE_TAG_BITS-1:0]  Tag,
  output cacheLineT                    Line
);

  logic [`ICACHE_SETS-1:0]      validBits;
  logic [`ICACHE_TAG_BITS-1:0]  tagMem [`ICACHE_SETS];
  cacheLineT                    lineMem [`ICACHE_SETS];
  logic                         firstWord;

  // word 0 opens a new line in this set.
  assign firstWord = WE & (Word == '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      validBits <= '0;  // every set starts empty.
    end else if (firstWord) begin
      validBits[Index] <= 1'b1;
    end
  end

  // tag goes in with the first word.
  always_ff @(posedge clk) begin
    if (firstWord) begin
      tagMem[Index] <= WriteTag;
    end
  end

  // one word per accepted beat.
  always_ff @(posedge clk) begin
    if (WE) begin
      lineMem[Index].words[Word] <= WriteData;
    end
  end

  // lookup is combinational on the index.
  assign Valid = validBits[Index];
  assign Tag   = tagMem[Index];
  assign Line  = lineMem[Index];

  // a write needs a known set, else some line gets trashed.
  knownIndex: assert property (@(posedge clk) disable iff (reset)
    WE |-> !$isunknown(Index));

endmodule

`default_nettype wire

/* source/icache_params.svh */
// Address, line, index and tag widths for the instruction cache.
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// fetch address and word sizes.
`define ICACHE_ADDR_BITS  32
`define ICACHE_WORD_WIDTH 32
`define ICACHE_BYTE_BITS  2

// line geometry, four words per line.
`define ICACHE_WORD_BITS  2
`define ICACHE_WORDS      (1 << `ICACHE_WORD_BITS)
`define ICACHE_LINE_BITS  (`ICACHE_WORDS * `ICACHE_WORD_WIDTH)

// sixteen sets per way.
`define ICACHE_SET_BITS   4
`define ICACHE_SETS       (1 << `ICACHE_SET_BITS)

// whatever is left above index and offsets.
`define ICACHE_TAG_BITS (`ICACHE_ADDR_BITS - `ICACHE_SET_BITS - `ICACHE_WORD_BITS - `ICACHE_BYTE_BITS)

`endif

/* source/icache_pkg.sv */
// Shared types of the instruction cache: the cache line union.
`default_nettype none

`include "icache_params.svh"

package icache_pkg;

  // a line as stored by a way, or as words picked by the read path.
  typedef union packed {
    logic [`ICACHE_LINE_BITS-1:0] raw;  // whole line.
    logic [`ICACHE_WORDS-1:0][`ICACHE_WORD_WIDTH-1:0] words;  // word 0 at the bottom.
  } cacheLineT;

endpackage

`default_nettype wire

/* test/icacheTb.sv */
// Instruction cache testbench: clock, reset, fetch tables, LRU reference model and checks.
`default_nettype none

`include "icache_params.svh"

module icacheTb;

  localparam int PERIOD         = 100;
  localparam int DRIVE_DELAY    = 10;
  localparam int FETCH_TIMEOUT  = 200;
  localparam int DIRECTED       = 16;
  localparam int RANDOM_FETCHES = 40;

  logic        clk = 1'b1;
  logic        reset;
  logic [31:0] PCF;
  logic [31:0] HRData;
  logic        BusReady;
  logic [31:0] InstrF;
  logic        IStall;
  logic        HRequestF;
  logic [31:0] HAddrF;

  // directed fetches, expected miss in bit 32.
  logic [32:0] fetchTable [DIRECTED];
  logic [31:0] randomAddr [RANDOM_FETCHES];

  // reference two-way LRU state per set.
  logic [`ICACHE_TAG_BITS-1:0] modelTag [`ICACHE_SETS][2];
  logic                        modelValid [`ICACHE_SETS][2];
  int                          modelLru [`ICACHE_SETS];  // way to replace next.

  integer seed = 32'hd2381692;
  int     errorCount = 0;

  always #(PERIOD / 2) clk = ~clk;

  icache DUT (
    .clk(clk), .reset(reset), .PCF(PCF), .HRData(HRData), .BusReady(BusReady),
    .InstrF(InstrF), .IStall(IStall), .HRequestF(HRequestF), .HAddrF(HAddrF)
  );

  memModel mem (.clk(clk), .HAddrF(HAddrF), .HRData(HRData), .BusReady(BusReady));

  task automatic stopRun(input string reason);
    errorCount++;
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      stopRun($sformatf("error %s: got %h, expected %h", name, actual, expected));
    end
  endtask

  function automatic logic [31:0] expectedInstr(input logic [31:0] addr);
    expectedInstr = {2'b00, addr[31:2]} ^ 32'h5a5a0000;
  endfunction

  // looks up the model, fills on a miss and returns the miss flag.
  function automatic logic modelAccess(input logic [31:0] addr);
    int                          setIdx;
    int                          way;
    logic [`ICACHE_TAG_BITS-1:0] tag;
    logic                        miss;
    setIdx = addr[`ICACHE_BYTE_BITS + `ICACHE_WORD_BITS +: `ICACHE_SET_BITS];
    tag    = addr[31 -: `ICACHE_TAG_BITS];
    miss   = 1'b1;
    way    = 0;
    for (int w = 0; w < 2; w++) begin
      if (modelValid[setIdx][w] && modelTag[setIdx][w] == tag) begin
        miss = 1'b0;
        way  = w;
      end
    end
    if (miss) begin
      if (!modelValid[setIdx][0]) way = 0;
      else if (!modelValid[setIdx][1]) way = 1;
      else way = modelLru[setIdx];
      modelValid[setIdx][way] = 1'b1;
      modelTag[setIdx][way]   = tag;
    end
    modelLru[setIdx] = 1 - way;  // the other way is now oldest.
    return miss;
  endfunction

  task automatic loadTables;
    int tagSel;
    fetchTable[0]  = {1'b1, 32'h0000_1040};  // cold miss after reset.
    fetchTable[1]  = {1'b0, 32'h0000_1044};
    fetchTable[2]  = {1'b0, 32'h0000_1048};
    fetchTable[3]  = {1'b0, 32'h0000_104c};  // word 3 from the array.
    fetchTable[4]  = {1'b1, 32'h0000_2040};  // same set, second tag.
    fetchTable[5]  = {1'b0, 32'h0000_1048};
    fetchTable[6]  = {1'b0, 32'h0000_204c};
    fetchTable[7]  = {1'b0, 32'h0000_1040};
    fetchTable[8]  = {1'b0, 32'h0000_2044};
    fetchTable[9]  = {1'b1, 32'h0000_304c};  // third tag evicts 0x1040, bypass word.
    fetchTable[10] = {1'b0, 32'h0000_2048};
    fetchTable[11] = {1'b1, 32'h0000_1044};  // evicted line comes back.
    fetchTable[12] = {1'b1, 32'h0000_3040};
    fetchTable[13] = {1'b0, 32'h0000_1040};
    fetchTable[14] = {1'b1, 32'h0000_2048};
    fetchTable[15] = {1'b0, 32'h0000_104c};
    // three tags over every set, random word.
    for (int i = 0; i < RANDOM_FETCHES; i++) begin
      tagSel        = $unsigned($random(seed)) % 3;
      randomAddr[i] = 32'h0004_0000 | (tagSel << 8) | ((i % `ICACHE_SETS) << 4)
                      | (($unsigned($random(seed)) % 4) << 2);
    end
  endtask

  task automatic clearModel;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      modelValid[s][0] = 1'b0;
      modelValid[s][1] = 1'b0;
      modelLru[s]      = 0;
    end
  endtask

  task automatic drivePc(input logic [31:0] addr);
    @(posedge clk);
    #DRIVE_DELAY;
    PCF = addr;
  endtask

  // follows one fetch to the end of any stall and checks beats and data.
  task automatic completeFetch(input logic [31:0] addr, input logic expectMiss);
    logic [31:0] lineBase;
    int          beats;
    int          cycles;
    bit          done;
    lineBase = addr & ~32'hf;
    beats    = 0;
    cycles   = 0;
    done     = 1'b0;
    @(negedge clk);
    checkValue("IStall", IStall, expectMiss);
    checkValue("HRequestF", HRequestF, expectMiss);
    while (!done) begin
      if (!IStall) begin
        done = 1'b1;
      end else begin
        checkValue("HRequestF", HRequestF, 1'b1);
        if (BusReady) begin
          checkValue("HAddrF", HAddrF, lineBase + 4 * beats);  // accepted at next edge.
          beats++;
        end
        cycles++;
        if (cycles > FETCH_TIMEOUT) begin
          stopRun($sformatf("timeout: IStall stayed high while fetching %h", addr));
        end
        @(negedge clk);
      end
    end
    checkValue("accepted beats", beats, expectMiss ? 4 : 0);
    checkValue("InstrF", InstrF, expectedInstr(addr));
  endtask

  initial begin
    logic [31:0] addr;
    logic        miss;
    loadTables();
    clearModel();
    reset = 1'b1;
    PCF   = fetchTable[0][31:0];
    // ready toggles under reset, yet no request goes out and no beat moves the counter.
    repeat (2) begin
      @(negedge clk);
      checkValue("HRequestF", HRequestF, 1'b0);
      checkValue("HAddrF", HAddrF, PCF & ~32'hf);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;

    for (int i = 0; i < DIRECTED; i++) begin
      addr = fetchTable[i][31:0];
      miss = modelAccess(addr);
      if (miss !== fetchTable[i][32]) begin
        stopRun($sformatf("LRU model and fetch table disagree at address %h", addr));
      end
      if (i > 0) drivePc(addr);
      completeFetch(addr, miss);
    end

    for (int i = 0; i < RANDOM_FETCHES; i++) begin
      addr = randomAddr[i];
      miss = modelAccess(addr);
      drivePc(addr);
      completeFetch(addr, miss);
    end

    @(posedge clk);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/memModel.sv */
// Behavioral instruction memory for the cache refill bus, with random ready gaps.
`default_nettype none

module memModel #(
  parameter int          driveDelay = 10,
  parameter logic [31:0] dataKey    = 32'h5a5a0000
) (
  input  logic        clk,
  input  logic [31:0] HAddrF,
  output logic [31:0] HRData,
  output logic        BusReady
);

  integer seed;
  int     waitLeft;  // idle cycles before the next ready.

  initial begin
    seed     = 32'hd2381692;
    waitLeft = 0;
    BusReady = 1'b0;
  end

  // contents follow from the word address alone.
  assign HRData = {2'b00, HAddrF[31:2]} ^ dataKey;

  // each ready cycle is followed by a gap of zero to three cycles.
  always @(posedge clk) begin
    #driveDelay;
    if (waitLeft == 0) begin
      BusReady = 1'b1;
      waitLeft = $unsigned($random(seed)) % 4;
    end else begin
      BusReady = 1'b0;
      waitLeft = waitLeft - 1;
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+source
source/icache_pkg.sv
source/icacheController.sv
source/icacheWay.sv
source/icacheLru.sv
source/icacheReadPath.sv
source/icache.sv
test/memModel.sv
test/icacheTb.sv
